/* hw/gesture_i2c_ctrl.sv */
`timescale 1ns/1ps

module gesture_i2c_ctrl import sensor_pkg::*; (
    input  logic i2c_clk,
    input  logic sys_rst_n,
    output logic scl,
    inout  wire  sda,
    output logic init_done
);

    logic       xfer_start;
    xfer_kind_t xfer_kind;
    logic [7:0] reg_addr;
    logic [7:0] wr_data;
    logic       xfer_done;
    logic       xfer_nack;
    logic [7:0] rd_data;
    logic       sda_oe;
    logic       sda_in;

    // open drain, pull-up sits on the board
    assign sda    = sda_oe ? 1'b0 : 1'bz;
    assign sda_in = sda;

    sensor_init_seq u_seq (
        .i2c_clk    (i2c_clk),
        .sys_rst_n  (sys_rst_n),
        .xfer_start (xfer_start),
        .xfer_kind  (xfer_kind),
        .reg_addr   (reg_addr),
        .wr_data    (wr_data),
        .xfer_done  (xfer_done),
        .xfer_nack  (xfer_nack),
        .rd_data    (rd_data),
        .init_done  (init_done)
    );

    i2c_byte_engine u_engine (
        .i2c_clk    (i2c_clk),
        .sys_rst_n  (sys_rst_n),
        .xfer_start (xfer_start),
        .xfer_kind  (xfer_kind),
        .reg_addr   (reg_addr),
        .wr_data    (wr_data),
        .sda_in     (sda_in),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .xfer_done  (xfer_done),
        .xfer_nack  (xfer_nack),
        .rd_data    (rd_data)
    );

endmodule

/* hw/i2c_byte_engine.sv */
`timescale 1ns/1ps
`include "i2c_cfg.svh"

module i2c_byte_engine import i2c_pkg::*, sensor_pkg::*; (
    input  logic       i2c_clk,
    input  logic       sys_rst_n,
    input  logic       xfer_start,
    input  xfer_kind_t xfer_kind,
    input  logic [7:0] reg_addr,
    input  logic [7:0] wr_data,
    input  logic       sda_in,
    output logic       scl,
    output logic       sda_oe,
    output logic       xfer_done,
    output logic       xfer_nack,
    output logic [7:0] rd_data
);

    localparam int q_w = $clog2(`I2C_QUARTERS);
    localparam logic [q_w-1:0] q_last   = q_w'(`I2C_QUARTERS - 1);
    localparam logic [q_w-1:0] q_sample = q_w'(1);
    localparam logic [q_w-1:0] q_mid    = q_w'(2);

    bus_phase_t     phase;
    logic [q_w-1:0] qtr;        // quarter within the current bit
    logic [2:0]     bit_cnt;
    logic [1:0]     byte_idx;   // byte of the transaction being sent
    logic [1:0]     last_idx;
    i2c_frame_t     frame;
    logic           nack_seen;
    logic           bit_end;
    logic           sample_pt;
    logic           scl_pulse;
    logic           sda_level;

    assign bit_end   = (qtr == q_last);
    assign sample_pt = (qtr == q_sample);
    assign scl_pulse = (qtr == q_sample) || (qtr == q_mid);

    // index of the last byte before stop
    always_comb begin
        case (xfer_kind)
            write_reg: last_idx = 2'd2;
            set_ptr:   last_idx = 2'd1;
            default:   last_idx = 2'd0;
        endcase
    end

    always_ff @(posedge i2c_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            qtr <= '0;
        end else if (phase == idle || bit_end) begin
            qtr <= '0;
        end else begin
            qtr <= qtr + 1'b1;
        end
    end

    always_ff @(posedge i2c_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            phase    <= idle;
            bit_cnt  <= '0;
            byte_idx <= '0;
        end else begin
            case (phase)
                idle: begin
                    if (xfer_start) begin
                        phase    <= start;
                        byte_idx <= '0;
                    end
                end
                start: begin
                    if (bit_end) begin
                        phase   <= send_byte;
                        bit_cnt <= '0;
                    end
                end
                send_byte: begin
                    if (bit_end) begin
                        if (bit_cnt == 3'd7) begin
                            phase <= (xfer_kind == wake) ? stop : get_ack;  // wake has no ack
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                get_ack: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        if (nack_seen) begin
                            phase <= stop;                 // abort, release the bus
                        end else if (xfer_kind == read_byte) begin
                            phase <= recv_byte;
                        end else if (byte_idx == last_idx) begin
                            phase <= stop;
                        end else begin
                            phase    <= send_byte;
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                recv_byte: begin
                    if (bit_end) begin
                        if (bit_cnt == 3'd7) begin
                            phase <= send_nack;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                send_nack: begin
                    if (bit_end) begin
                        phase <= stop;
                    end
                end
                stop: begin
                    if (bit_end) begin
                        phase <= idle;
                    end
                end
                default: phase <= idle;
            endcase
        end
    end

    // sticky over the whole transaction
    always_ff @(posedge i2c_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            nack_seen <= 1'b0;
        end else if (phase == idle && xfer_start) begin
            nack_seen <= 1'b0;
        end else if (phase == get_ack && sample_pt && sda_in) begin
            nack_seen <= 1'b1;
        end
    end

    always_ff @(posedge i2c_clk) begin
        case (phase)
            start: begin
                if (bit_end) begin
                    frame.addr.dev_addr <= `I2C_SLAVE_ADDR;
                    frame.addr.rw       <= (xfer_kind == read_byte);
                end
            end
            send_byte: begin
                if (bit_end) begin
                    frame.raw <= {frame.raw[6:0], 1'b0};
                end
            end
            get_ack: begin
                if (bit_end) begin
                    frame.raw <= (byte_idx == 2'd0) ? reg_addr : wr_data;  // next byte out
                end
            end
            recv_byte: begin
                if (sample_pt) begin
                    frame.raw <= {frame.raw[6:0], sda_in};
                end
            end
            default: begin
            end
        endcase
    end

    // bus pins decoded from phase and quarter
    always_comb begin
        scl       = 1'b1;
        sda_level = 1'b1;
        case (phase)
            start: begin
                scl       = (qtr != q_last);
                sda_level = (qtr < q_mid);
            end
            send_byte: begin
                scl       = scl_pulse;
                sda_level = frame.raw[7];
            end
            get_ack, recv_byte, send_nack: begin
                scl = scl_pulse;               // sda left to the slave or high
            end
            stop: begin
                scl       = (qtr != '0);
                sda_level = (qtr >= q_mid);
            end
            default: begin
            end
        endcase
    end

    assign sda_oe    = ~sda_level;
    assign xfer_done = (phase == stop) && bit_end;
    assign xfer_nack = xfer_done && nack_seen;
    assign rd_data   = frame.raw;

endmodule

/* hw/i2c_cfg.svh */
`ifndef I2C_CFG_SVH
`define I2C_CFG_SVH

// 7-bit device address of the gesture sensor
`define I2C_SLAVE_ADDR 7'h73

// idle i2c_clk cycles ahead of every transaction
`define I2C_WAIT_TICKS 1000

// bank select register and the value for bank 0
`define I2C_BANK_REG  8'hEF
`define I2C_BANK0_VAL 8'h00

// part id register and its expected content
`define I2C_ID_REG    8'h00
`define I2C_ID_EXPECT 8'h20

// i2c_clk cycles per bus bit
// scl high in quarters 1 and 2, sda moves in quarter 0
`define I2C_QUARTERS 4

`endif

/* hw/i2c_pkg.sv */
package i2c_pkg;

    // one byte on the wire, either an address frame or plain data
    typedef union packed {
        struct packed {
            logic [6:0] dev_addr;  // 7-bit device address
            logic       rw;        // 1 = read
        } addr;
        logic [7:0] raw;           // data byte, msb goes out first
    } i2c_frame_t;

    // engine phase, each phase lasts one or more 4-quarter bits
    typedef enum logic [2:0] {
        idle      = 3'd0,  // bus released
        start     = 3'd1,  // sda falls with scl high
        send_byte = 3'd2,  // 8 bits driven by master
        get_ack   = 3'd3,  // slave acknowledge slot
        recv_byte = 3'd4,  // 8 bits driven by slave
        send_nack = 3'd5,  // master leaves sda high
        stop      = 3'd6   // sda rises with scl high
    } bus_phase_t;

endpackage

/* hw/sensor_init_seq.sv */
`timescale 1ns/1ps
`include "i2c_cfg.svh"

module sensor_init_seq import sensor_pkg::*; (
    input  logic       i2c_clk,
    input  logic       sys_rst_n,
    output logic       xfer_start,
    output xfer_kind_t xfer_kind,
    output logic [7:0] reg_addr,
    output logic [7:0] wr_data,
    input  logic       xfer_done,
    input  logic       xfer_nack,
    input  logic [7:0] rd_data,
    output logic       init_done
);

    localparam int wait_w = $clog2(`I2C_WAIT_TICKS);
    localparam logic [wait_w-1:0] wait_last = wait_w'(`I2C_WAIT_TICKS - 1);

    init_step_t        step;
    init_step_t        next_step;
    logic              busy;       // transaction in flight
    logic [wait_w-1:0] wait_cnt;
    logic              wait_end;
    logic              id_match;

    assign wait_end = (wait_cnt == wait_last);
    assign id_match = (rd_data == `I2C_ID_EXPECT);

    // command for each step, held while busy
    always_comb begin
        case (step)
            step_bank: begin
                xfer_kind = write_reg;
                reg_addr  = `I2C_BANK_REG;
                wr_data   = `I2C_BANK0_VAL;
            end
            step_ptr: begin
                xfer_kind = set_ptr;
                reg_addr  = `I2C_ID_REG;
                wr_data   = 8'h00;
            end
            step_read: begin
                xfer_kind = read_byte;
                reg_addr  = `I2C_ID_REG;
                wr_data   = 8'h00;
            end
            default: begin
                xfer_kind = wake;
                reg_addr  = 8'h00;
                wr_data   = 8'h00;
            end
        endcase
    end

    always_comb begin
        case (step)
            step_wake: next_step = step_bank;
            step_bank: next_step = step_ptr;
            step_ptr:  next_step = step_read;
            step_read: next_step = id_match ? step_done : step_wake;  // wrong id, start over
            default:   next_step = step_done;
        endcase
    end

    always_ff @(posedge i2c_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wait_cnt   <= '0;
            xfer_start <= 1'b0;
            busy       <= 1'b0;
        end else begin
            xfer_start <= 1'b0;
            if (busy) begin
                if (xfer_done) begin
                    busy <= 1'b0;
                end
            end else if (step != step_done) begin
                if (wait_end) begin
                    wait_cnt   <= '0;
                    xfer_start <= 1'b1;
                    busy       <= 1'b1;
                end else begin
                    wait_cnt <= wait_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i2c_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            step <= step_wake;
        end else if (busy && xfer_done) begin
            step <= xfer_nack ? step_wake : next_step;
        end
    end

    assign init_done = (step == step_done);  // stays until reset

endmodule

/* hw/sensor_pkg.sv */
package sensor_pkg;

    // kind of bus transaction the sequencer asks for
    typedef enum logic [1:0] {
        wake      = 2'd0,  // address byte then stop, no ack slot
        write_reg = 2'd1,  // address, register, data
        set_ptr   = 2'd2,  // address, register
        read_byte = 2'd3   // address with read, one byte, nack
    } xfer_kind_t;

    // position in the wake and identify sequence
    typedef enum logic [2:0] {
        step_wake = 3'd0,
        step_bank = 3'd1,
        step_ptr  = 3'd2,
        step_read = 3'd3,
        step_done = 3'd4   // id matched, bus stays idle
    } init_step_t;

endpackage

/* list.f */
+incdir+hw
hw/i2c_pkg.sv
hw/sensor_pkg.sv
hw/i2c_byte_engine.sv
hw/sensor_init_seq.sv
hw/gesture_i2c_ctrl.sv
sim/i2c_slave_model.sv
sim/tb_gesture_i2c_ctrl.sv

/* sim/i2c_slave_model.sv */
`timescale 1ns/1ps
`include "i2c_cfg.svh"

module i2c_slave_model import i2c_pkg::*; (
    input  logic        clk,           // bus sampled on the falling edge
    input  logic        rst_n,
    input  logic        scl,
    inout  wire         sda,
    input  logic [7:0]  id_byte,       // returned on a read
    input  int          refuse_frame,  // frame number that loses one ack
    input  int          refuse_byte,
    output int          frame_cnt,
    output int          frame_len,
    output int          frame_clks,    // scl pulses from start to stop
    output logic [31:0] frame_word,    // first byte in the top bits
    output logic        master_nack
);

    logic       scl_q;
    logic       sda_q;
    logic       sda_s;
    logic       drive;
    logic       active;
    logic       asleep;     // no ack until a frame has woken it
    logic       sending;
    logic       was_tx;
    logic       refused;
    int         bit_n;
    int         clk_n;
    logic [7:0] shift;
    logic [7:0] tx;
    i2c_frame_t head;
    logic [7:0] rx_q[$];

    assign sda = drive ? 1'b0 : 1'bz;

    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_q = 1'b1;
            sda_q = 1'b1;
            drive = 1'b0;
            active = 1'b0;
            asleep = 1'b1;
            sending = 1'b0;
            was_tx = 1'b0;
            refused = 1'b0;
            bit_n = 0;
            clk_n = 0;
            head.raw = 8'h00;
            frame_cnt = 0;
            frame_len = 0;
            frame_clks = 0;
            frame_word = '0;
            master_nack = 1'b0;
            rx_q.delete();
        end else begin
            sda_s = (sda !== 1'b0);
            if (scl_q && scl && sda_q && !sda_s) begin          // start
                active = 1'b1;
                bit_n = 0;
                clk_n = 0;
                sending = 1'b0;
                was_tx = 1'b0;
                refused = 1'b0;
                master_nack = 1'b0;
                rx_q.delete();
            end else if (active && scl_q && scl && !sda_q && sda_s) begin  // stop
                frame_word = '0;
                for (int i = 0; i < rx_q.size() && i < 4; i++) begin
                    frame_word[31 - 8 * i -: 8] = rx_q[i];
                end
                frame_len = rx_q.size();
                frame_clks = clk_n;
                // a read or a refused byte sends the sensor back to sleep
                asleep = refused || (rx_q.size() > 0 && head.addr.rw);
                active = 1'b0;
                drive = 1'b0;
                frame_cnt = frame_cnt + 1;
            end else if (active && !scl_q && scl) begin
                clk_n = clk_n + 1;
                if (bit_n < 8) begin
                    shift = {shift[6:0], sda_s};
                    bit_n = bit_n + 1;
                    if (bit_n == 8) begin
                        if (rx_q.size() == 0) begin
                            head.raw = shift;
                        end
                        rx_q.push_back(shift);
                    end
                end else begin
                    if (was_tx) begin
                        master_nack = sda_s;       // high means nack
                    end
                    bit_n = 0;
                end
            end else if (active && scl_q && !scl) begin
                if (bit_n == 8) begin
                    was_tx = sending;
                    sending = 1'b0;
                    if (was_tx || asleep || head.addr.dev_addr != `I2C_SLAVE_ADDR) begin
                        drive = 1'b0;
                    end else if (frame_cnt == refuse_frame && rx_q.size() == refuse_byte + 1) begin
                        drive = 1'b0;
                        refused = 1'b1;
                    end else begin
                        drive = 1'b1;
                    end
                end else if (bit_n == 0) begin
                    if (drive && head.addr.rw && rx_q.size() == 1) begin
                        sending = 1'b1;            // data follows the acked read address
                        tx = id_byte;
                        drive = !tx[7];
                    end else begin
                        drive = 1'b0;
                    end
                end else if (sending) begin
                    drive = !tx[7 - bit_n];
                end
            end
            scl_q = scl;
            sda_q = sda_s;
        end
    end

endmodule

/* sim/tb_gesture_i2c_ctrl.sv */
`timescale 1ns/1ps
`include "i2c_cfg.svh"

module tb_gesture_i2c_ctrl;

    // four waits plus 79 bits per full pass
    localparam int pass_cycles = 4 * `I2C_WAIT_TICKS + 79 * `I2C_QUARTERS;

    logic        i2c_clk;
    logic        sys_rst_n;
    wire         scl;
    wire         sda;
    wire         init_done;
    logic [7:0]  id_byte;
    int          refuse_frame;
    int          refuse_byte;
    int          frame_cnt;
    int          frame_len;
    int          frame_clks;
    logic [31:0] frame_word;
    logic        master_nack;
    integer      seed;
    int          cyc;
    int          cyc_limit;
    int          exp_idx;
    logic [31:0] exp_frame[$];
    int          exp_len[$];
    int          exp_clks[$];

    pullup (sda);

    gesture_i2c_ctrl u_gesture_i2c_ctrl (
        .i2c_clk   (i2c_clk),
        .sys_rst_n (sys_rst_n),
        .scl       (scl),
        .sda       (sda),
        .init_done (init_done)
    );

    i2c_slave_model u_slave (
        .clk          (i2c_clk),
        .rst_n        (sys_rst_n),
        .scl          (scl),
        .sda          (sda),
        .id_byte      (id_byte),
        .refuse_frame (refuse_frame),
        .refuse_byte  (refuse_byte),
        .frame_cnt    (frame_cnt),
        .frame_len    (frame_len),
        .frame_clks   (frame_clks),
        .frame_word   (frame_word),
        .master_nack  (master_nack)
    );

    initial begin
        i2c_clk = 1'b0;
        forever #20 i2c_clk = ~i2c_clk;
    end

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic void add_frame(input logic [31:0] word, input int len, input int pulses);
        exp_frame.push_back(word);
        exp_len.push_back(len);
        exp_clks.push_back(pulses);
    endfunction

    // expected frames of a scenario with the first byte on top
    // nine scl pulses per byte with its ack slot and one more for stop
    function automatic void build_expected(input int scen, input logic [7:0] first_id,
                                           input int cut);
        logic [7:0]  aw;
        logic [7:0]  ar;
        logic [31:0] bank_f;
        logic        last;
        int          n_pass;
        aw = {`I2C_SLAVE_ADDR, 1'b0};
        ar = {`I2C_SLAVE_ADDR, 1'b1};
        bank_f = {aw, `I2C_BANK_REG, `I2C_BANK0_VAL, 8'h00};
        n_pass = (scen == 0) ? 1 : 2;
        exp_frame.delete();
        exp_len.delete();
        exp_clks.delete();
        for (int p = 0; p < n_pass; p++) begin
            last = (p == n_pass - 1);
            add_frame({aw, 24'h0}, 1, 8 + 1);          // no ack slot before stop
            if (scen == 2 && !last) begin
                // bank write ends after the refused byte
                add_frame(bank_f & ~(32'hffff_ffff >> (8 * (cut + 1))), cut + 1,
                          (cut + 1) * 9 + 1);
            end else begin
                add_frame(bank_f, 3, 3 * 9 + 1);
                add_frame({aw, `I2C_ID_REG, 16'h0}, 2, 2 * 9 + 1);
                add_frame({ar, (last ? `I2C_ID_EXPECT : first_id), 16'h0}, 2, 9 + 9 + 1);
            end
        end
    endfunction

    task automatic watch_idle_bus(input int cycles, input logic done_exp);
        int cnt0;
        cnt0 = frame_cnt;
        repeat (cycles) begin
            @(negedge i2c_clk);
            check_val(scl, 1'b1, "scl not idle");
            check_val(sda, 1'b1, "sda not idle");
            check_val(init_done, done_exp, "init_done level");
            check_val(frame_cnt, cnt0, "frame seen on idle bus");
        end
    endtask

    always @(posedge i2c_clk) begin
        if (!sys_rst_n) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
            if (cyc > cyc_limit) begin
                $display("timeout: the init sequence did not finish within %0d cycles", cyc_limit);
                $display("TEST FAILED");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin : compare_frames
        forever begin
            @(frame_cnt);
            if (frame_cnt != 0) begin
                @(negedge i2c_clk);
                check_val(exp_idx < exp_len.size(), 1'b1, "frame beyond the expected list");
                check_val(frame_len, exp_len[exp_idx], "frame length");
                check_val(frame_word, exp_frame[exp_idx], "frame bytes");
                check_val(frame_clks, exp_clks[exp_idx], "scl pulses in frame");
                check_val(init_done, 1'b0, "init_done before the last read ended");
                if (exp_frame[exp_idx][24]) begin
                    check_val(master_nack, 1'b1, "master nack after read byte");
                    id_byte = `I2C_ID_EXPECT;   // next pass reads the right id
                end
                exp_idx = exp_idx + 1;
            end
        end
    end

    initial begin : run_scenarios
        logic [7:0] bad_id;
        int         cut;
        seed = 32'he11f_0c8e;
        sys_rst_n = 1'b0;
        id_byte = `I2C_ID_EXPECT;
        refuse_frame = -1;
        refuse_byte = 0;
        // 0 plain run, 1 wrong id first, 2 refused ack in bank write
        for (int scen = 0; scen < 3; scen++) begin
            bad_id = $random(seed);
            while (bad_id == `I2C_ID_EXPECT) begin
                bad_id = $random(seed);
            end
            cut = $unsigned($random(seed)) % 3;
            @(negedge i2c_clk);
            sys_rst_n = 1'b0;
            id_byte = (scen == 1) ? bad_id : `I2C_ID_EXPECT;
            refuse_frame = (scen == 2) ? 1 : -1;
            refuse_byte = cut;
            cyc_limit = ((scen == 0) ? 1 : 2) * pass_cycles * 2;
            build_expected(scen, bad_id, cut);
            exp_idx = 0;
            repeat (3) @(negedge i2c_clk);
            sys_rst_n = 1'b1;
            watch_idle_bus(`I2C_WAIT_TICKS, 1'b0);
            while (!(init_done && exp_idx == exp_len.size())) begin
                @(negedge i2c_clk);
            end
            watch_idle_bus(2 * `I2C_WAIT_TICKS, 1'b1);   // no start after init_done
        end
        $display("TEST OK");
        $finish;
    end

endmodule
